// ==== build.f ====
hdl/e203_pkg.sv
hdl/e203_dtcm_ram.sv
hdl/e203_dtcm_ctrl.sv
hdl/e203_biu_splitter.sv
hdl/e203_cpu_top.sv
sim/e203_cpu_top_properties.sv
sim/tb_clk_gen.sv
sim/tb_top.sv

// ==== hdl/e203_biu_splitter.sv ====
// ICB region splitter
`timescale 1ns/1ps
`default_nettype none

module e203_biu_splitter import e203_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Core side
  input  logic       core_icb_cmd_valid,
  output logic       core_icb_cmd_ready,
  input  addr_t      core_icb_cmd_addr,
  input  logic       core_icb_cmd_read,
  input  data_t      core_icb_cmd_wdata,
  input  mask_t      core_icb_cmd_wmask,
  output logic       core_icb_rsp_valid,
  input  logic       core_icb_rsp_ready,
  output logic       core_icb_rsp_err,
  output data_t      core_icb_rsp_rdata,

  // DTCM controller
  output logic       dtcm_icb_cmd_valid,
  input  logic       dtcm_icb_cmd_ready,
  output dtcm_addr_t dtcm_icb_cmd_addr,
  output logic       dtcm_icb_cmd_read,
  output data_t      dtcm_icb_cmd_wdata,
  output mask_t      dtcm_icb_cmd_wmask,
  input  logic       dtcm_icb_rsp_valid,
  output logic       dtcm_icb_rsp_ready,
  input  logic       dtcm_icb_rsp_err,
  input  data_t      dtcm_icb_rsp_rdata,

  // Private peripheral port
  output logic       ppi_icb_cmd_valid,
  input  logic       ppi_icb_cmd_ready,
  output addr_t      ppi_icb_cmd_addr,
  output logic       ppi_icb_cmd_read,
  output data_t      ppi_icb_cmd_wdata,
  output mask_t      ppi_icb_cmd_wmask,
  input  logic       ppi_icb_rsp_valid,
  output logic       ppi_icb_rsp_ready,
  input  logic       ppi_icb_rsp_err,
  input  data_t      ppi_icb_rsp_rdata,

  // System memory port
  output logic       mem_icb_cmd_valid,
  input  logic       mem_icb_cmd_ready,
  output addr_t      mem_icb_cmd_addr,
  output logic       mem_icb_cmd_read,
  output data_t      mem_icb_cmd_wdata,
  output mask_t      mem_icb_cmd_wmask,
  input  logic       mem_icb_rsp_valid,
  output logic       mem_icb_rsp_ready,
  input  logic       mem_icb_rsp_err,
  input  data_t      mem_icb_rsp_rdata
);

  target_e   cmd_tgt;
  target_e   rsp_tgt;
  target_e   tgt_fifo [OSTD_DEPTH];
  ostd_ptr_t wr_ptr;
  ostd_ptr_t rd_ptr;
  ostd_cnt_t ostd_cnt;
  logic      fifo_full;
  logic      fifo_empty;
  logic      cmd_go;
  logic      tgt_ready;
  logic      cmd_hsk;
  logic      head_valid;
  logic      rsp_hsk;

  function automatic ostd_ptr_t ptr_inc(input ostd_ptr_t ptr);
    return (ptr == ostd_ptr_t'(OSTD_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Command path

  always_comb begin
    if (core_icb_cmd_addr[ADDR_SIZE-1:DTCM_ADDR_WIDTH] ==
        DTCM_ADDR_BASE[ADDR_SIZE-1:DTCM_ADDR_WIDTH]) begin
      cmd_tgt = TGT_DTCM;
    end else if (core_icb_cmd_addr[ADDR_SIZE-1 -: PPI_REGION_BITS] ==
                 PPI_ADDR_BASE[ADDR_SIZE-1 -: PPI_REGION_BITS]) begin
      cmd_tgt = TGT_PPI;
    end else begin
      cmd_tgt = TGT_MEM;
    end
  end

  // Hold all targets off while the tracking FIFO has no room
  assign cmd_go = core_icb_cmd_valid & ~fifo_full;

  assign dtcm_icb_cmd_valid = cmd_go & (cmd_tgt == TGT_DTCM);
  assign ppi_icb_cmd_valid  = cmd_go & (cmd_tgt == TGT_PPI);
  assign mem_icb_cmd_valid  = cmd_go & (cmd_tgt == TGT_MEM);

  always_comb begin
    case (cmd_tgt)
      TGT_DTCM: tgt_ready = dtcm_icb_cmd_ready;
      TGT_PPI:  tgt_ready = ppi_icb_cmd_ready;
      default:  tgt_ready = mem_icb_cmd_ready;
    endcase
  end

  assign core_icb_cmd_ready = tgt_ready & ~fifo_full;
  assign cmd_hsk            = core_icb_cmd_valid & core_icb_cmd_ready;

  // Payload goes to every port, only the selected one sees valid
  assign dtcm_icb_cmd_addr  = core_icb_cmd_addr[DTCM_ADDR_WIDTH-1:0];
  assign dtcm_icb_cmd_read  = core_icb_cmd_read;
  assign dtcm_icb_cmd_wdata = core_icb_cmd_wdata;
  assign dtcm_icb_cmd_wmask = core_icb_cmd_wmask;

  assign ppi_icb_cmd_addr   = core_icb_cmd_addr;
  assign ppi_icb_cmd_read   = core_icb_cmd_read;
  assign ppi_icb_cmd_wdata  = core_icb_cmd_wdata;
  assign ppi_icb_cmd_wmask  = core_icb_cmd_wmask;

  assign mem_icb_cmd_addr   = core_icb_cmd_addr;
  assign mem_icb_cmd_read   = core_icb_cmd_read;
  assign mem_icb_cmd_wdata  = core_icb_cmd_wdata;
  assign mem_icb_cmd_wmask  = core_icb_cmd_wmask;

  //////////////////////////////////////////////////////////////////////////
  // Outstanding target FIFO

  always_ff @(posedge clk) begin
    if (cmd_hsk) begin
      tgt_fifo[wr_ptr] <= cmd_tgt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      ostd_cnt <= '0;
    end else begin
      if (cmd_hsk) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rsp_hsk) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({cmd_hsk, rsp_hsk})
        2'b10:   ostd_cnt <= ostd_cnt + 1'b1;
        2'b01:   ostd_cnt <= ostd_cnt - 1'b1;
        default: ostd_cnt <= ostd_cnt;
      endcase
    end
  end

  assign fifo_full  = (ostd_cnt == ostd_cnt_t'(OSTD_DEPTH));
  assign fifo_empty = (ostd_cnt == '0);

  //////////////////////////////////////////////////////////////////////////
  // Response path, only the oldest target may answer

  assign rsp_tgt = tgt_fifo[rd_ptr];

  always_comb begin
    case (rsp_tgt)
      TGT_DTCM: begin
        head_valid         = dtcm_icb_rsp_valid;
        core_icb_rsp_err   = dtcm_icb_rsp_err;
        core_icb_rsp_rdata = dtcm_icb_rsp_rdata;
      end
      TGT_PPI: begin
        head_valid         = ppi_icb_rsp_valid;
        core_icb_rsp_err   = ppi_icb_rsp_err;
        core_icb_rsp_rdata = ppi_icb_rsp_rdata;
      end
      default: begin
        head_valid         = mem_icb_rsp_valid;
        core_icb_rsp_err   = mem_icb_rsp_err;
        core_icb_rsp_rdata = mem_icb_rsp_rdata;
      end
    endcase
  end

  assign core_icb_rsp_valid = ~fifo_empty & head_valid;
  assign rsp_hsk            = core_icb_rsp_valid & core_icb_rsp_ready;

  assign dtcm_icb_rsp_ready = core_icb_rsp_ready & ~fifo_empty & (rsp_tgt == TGT_DTCM);
  assign ppi_icb_rsp_ready  = core_icb_rsp_ready & ~fifo_empty & (rsp_tgt == TGT_PPI);
  assign mem_icb_rsp_ready  = core_icb_rsp_ready & ~fifo_empty & (rsp_tgt == TGT_MEM);

endmodule

`default_nettype wire

// ==== hdl/e203_cpu_top.sv ====
// Data side memory subsystem top
`timescale 1ns/1ps
`default_nettype none

module e203_cpu_top import e203_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tcm_sd,

  // Core bus master
  input  logic       core_icb_cmd_valid,
  output logic       core_icb_cmd_ready,
  input  addr_t      core_icb_cmd_addr,
  input  logic       core_icb_cmd_read,
  input  data_t      core_icb_cmd_wdata,
  input  mask_t      core_icb_cmd_wmask,
  output logic       core_icb_rsp_valid,
  input  logic       core_icb_rsp_ready,
  output logic       core_icb_rsp_err,
  output data_t      core_icb_rsp_rdata,

  // External access to the DTCM
  input  logic       ext2dtcm_icb_cmd_valid,
  output logic       ext2dtcm_icb_cmd_ready,
  input  dtcm_addr_t ext2dtcm_icb_cmd_addr,
  input  logic       ext2dtcm_icb_cmd_read,
  input  data_t      ext2dtcm_icb_cmd_wdata,
  input  mask_t      ext2dtcm_icb_cmd_wmask,
  output logic       ext2dtcm_icb_rsp_valid,
  input  logic       ext2dtcm_icb_rsp_ready,
  output logic       ext2dtcm_icb_rsp_err,
  output data_t      ext2dtcm_icb_rsp_rdata,

  // Private peripheral port
  output logic       ppi_icb_cmd_valid,
  input  logic       ppi_icb_cmd_ready,
  output addr_t      ppi_icb_cmd_addr,
  output logic       ppi_icb_cmd_read,
  output data_t      ppi_icb_cmd_wdata,
  output mask_t      ppi_icb_cmd_wmask,
  input  logic       ppi_icb_rsp_valid,
  output logic       ppi_icb_rsp_ready,
  input  logic       ppi_icb_rsp_err,
  input  data_t      ppi_icb_rsp_rdata,

  // System memory port
  output logic       mem_icb_cmd_valid,
  input  logic       mem_icb_cmd_ready,
  output addr_t      mem_icb_cmd_addr,
  output logic       mem_icb_cmd_read,
  output data_t      mem_icb_cmd_wdata,
  output mask_t      mem_icb_cmd_wmask,
  input  logic       mem_icb_rsp_valid,
  output logic       mem_icb_rsp_ready,
  input  logic       mem_icb_rsp_err,
  input  data_t      mem_icb_rsp_rdata
);

  // Splitter to DTCM controller
  logic       dtcm_icb_cmd_valid;
  logic       dtcm_icb_cmd_ready;
  dtcm_addr_t dtcm_icb_cmd_addr;
  logic       dtcm_icb_cmd_read;
  data_t      dtcm_icb_cmd_wdata;
  mask_t      dtcm_icb_cmd_wmask;
  logic       dtcm_icb_rsp_valid;
  logic       dtcm_icb_rsp_ready;
  logic       dtcm_icb_rsp_err;
  data_t      dtcm_icb_rsp_rdata;

  // Controller to SRAM
  logic       ram_cs;
  logic       ram_we;
  ram_addr_t  ram_addr;
  mask_t      ram_wem;
  data_t      ram_din;
  data_t      ram_dout;

  ////////////////////////////////////////////////////////////////////////////
  // Port names match across the hierarchy

  e203_biu_splitter u_biu_splitter (.*);

  e203_dtcm_ctrl u_dtcm_ctrl (.*);

  e203_dtcm_ram u_dtcm_ram (.*);

endmodule

`default_nettype wire

// ==== hdl/e203_dtcm_ctrl.sv ====
// DTCM access controller
`timescale 1ns/1ps
`default_nettype none

module e203_dtcm_ctrl import e203_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // PMU shutdown, blocks every new access
  input  logic       tcm_sd,

  // From the region splitter
  input  logic       dtcm_icb_cmd_valid,
  output logic       dtcm_icb_cmd_ready,
  input  dtcm_addr_t dtcm_icb_cmd_addr,
  input  logic       dtcm_icb_cmd_read,
  input  data_t      dtcm_icb_cmd_wdata,
  input  mask_t      dtcm_icb_cmd_wmask,
  output logic       dtcm_icb_rsp_valid,
  input  logic       dtcm_icb_rsp_ready,
  output logic       dtcm_icb_rsp_err,
  output data_t      dtcm_icb_rsp_rdata,

  // External master
  input  logic       ext2dtcm_icb_cmd_valid,
  output logic       ext2dtcm_icb_cmd_ready,
  input  dtcm_addr_t ext2dtcm_icb_cmd_addr,
  input  logic       ext2dtcm_icb_cmd_read,
  input  data_t      ext2dtcm_icb_cmd_wdata,
  input  mask_t      ext2dtcm_icb_cmd_wmask,
  output logic       ext2dtcm_icb_rsp_valid,
  input  logic       ext2dtcm_icb_rsp_ready,
  output logic       ext2dtcm_icb_rsp_err,
  output data_t      ext2dtcm_icb_rsp_rdata,

  // SRAM port
  output logic       ram_cs,
  output logic       ram_we,
  output ram_addr_t  ram_addr,
  output mask_t      ram_wem,
  output data_t      ram_din,
  input  data_t      ram_dout
);

  logic       can_accept;
  logic       sel_ext;
  logic       cmd_accept;
  logic       rsp_vld;
  logic       rsp_from_ext;
  logic       rsp_taken;
  dtcm_addr_t cmd_addr;
  logic       cmd_read;
  data_t      cmd_wdata;
  mask_t      cmd_wmask;

  //////////////////////////////////////////////////////////////////////////
  // Arbitration

  // Response register frees up when empty or drained this cycle
  assign rsp_taken  = rsp_vld &
                      (rsp_from_ext ? ext2dtcm_icb_rsp_ready : dtcm_icb_rsp_ready);
  assign can_accept = ~tcm_sd & (~rsp_vld | rsp_taken);

  // Splitter side always wins
  assign sel_ext                = ~dtcm_icb_cmd_valid;
  assign dtcm_icb_cmd_ready     = can_accept;
  assign ext2dtcm_icb_cmd_ready = can_accept & sel_ext;

  assign cmd_accept = can_accept & (dtcm_icb_cmd_valid | ext2dtcm_icb_cmd_valid);

  always_comb begin
    if (sel_ext) begin
      cmd_addr  = ext2dtcm_icb_cmd_addr;
      cmd_read  = ext2dtcm_icb_cmd_read;
      cmd_wdata = ext2dtcm_icb_cmd_wdata;
      cmd_wmask = ext2dtcm_icb_cmd_wmask;
    end else begin
      cmd_addr  = dtcm_icb_cmd_addr;
      cmd_read  = dtcm_icb_cmd_read;
      cmd_wdata = dtcm_icb_cmd_wdata;
      cmd_wmask = dtcm_icb_cmd_wmask;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // SRAM access, one per accepted command

  assign ram_cs   = cmd_accept;
  assign ram_we   = ~cmd_read;
  assign ram_addr = cmd_addr[2 +: DTCM_RAM_AW];  // Word index
  assign ram_wem  = cmd_wmask;
  assign ram_din  = cmd_wdata;

  //////////////////////////////////////////////////////////////////////////
  // Response register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld      <= 1'b0;
      rsp_from_ext <= 1'b0;
    end else if (cmd_accept) begin
      rsp_vld      <= 1'b1;
      rsp_from_ext <= sel_ext;
    end else if (rsp_taken) begin
      rsp_vld      <= 1'b0;
    end
  end

  assign dtcm_icb_rsp_valid     = rsp_vld & ~rsp_from_ext;
  assign ext2dtcm_icb_rsp_valid = rsp_vld & rsp_from_ext;

  // Read data sits in the RAM output register until the next access
  assign dtcm_icb_rsp_rdata     = ram_dout;
  assign ext2dtcm_icb_rsp_rdata = ram_dout;

  // No error source inside the DTCM
  assign dtcm_icb_rsp_err       = 1'b0;
  assign ext2dtcm_icb_rsp_err   = 1'b0;

endmodule

`default_nettype wire

// ==== hdl/e203_dtcm_ram.sv ====
// DTCM single-port SRAM
`timescale 1ns/1ps
`default_nettype none

module e203_dtcm_ram import e203_pkg::*; (
  input  logic      clk,
  input  logic      ram_cs,
  input  logic      ram_we,
  input  ram_addr_t ram_addr,
  input  mask_t     ram_wem,
  input  data_t     ram_din,
  output data_t     ram_dout
);

  data_t mem_array [2**DTCM_RAM_AW];

  //////////////////////////////////////////////////////////////////////////
  // Write with per-byte enables

  always_ff @(posedge clk) begin
    if (ram_cs && ram_we) begin
      for (int i = 0; i < $bits(mask_t); i++) begin
        if (ram_wem[i]) begin
          mem_array[ram_addr][8*i +: 8] <= ram_din[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read

  // Output only changes on a read, so it holds across stalls and writes
  always_ff @(posedge clk) begin
    if (ram_cs && !ram_we) begin
      ram_dout <= mem_array[ram_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/e203_pkg.sv ====
// Data side memory subsystem definitions
`default_nettype none

package e203_pkg;

  // Bus widths
  localparam int XLEN            = 32;
  localparam int ADDR_SIZE       = 32;
  localparam int DTCM_ADDR_WIDTH = 16;
  localparam int DTCM_RAM_AW     = 14;

  typedef logic [ADDR_SIZE-1:0]       addr_t;
  typedef logic [XLEN-1:0]            data_t;
  typedef logic [XLEN/8-1:0]          mask_t;
  typedef logic [DTCM_ADDR_WIDTH-1:0] dtcm_addr_t;
  typedef logic [DTCM_RAM_AW-1:0]     ram_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address region map

  // DTCM matches on the bits above the 64 KiB offset
  localparam addr_t DTCM_ADDR_BASE = 32'h9000_0000;

  // PPI matches on the top PPI_REGION_BITS bits
  localparam addr_t PPI_ADDR_BASE   = 32'h1000_0000;
  localparam int    PPI_REGION_BITS = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Splitter outstanding tracking

  localparam int OSTD_DEPTH = 2;
  localparam int OSTD_PTR_W = $clog2(OSTD_DEPTH);
  localparam int OSTD_CNT_W = $clog2(OSTD_DEPTH + 1);

  typedef logic [OSTD_PTR_W-1:0] ostd_ptr_t;
  typedef logic [OSTD_CNT_W-1:0] ostd_cnt_t;

  // Targets of the region splitter, anything unmatched goes to MEM
  typedef enum logic [1:0] {
    TGT_DTCM,
    TGT_PPI,
    TGT_MEM
  } target_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_top \
  -Mdir obj_dir -o tb_top_sim

# The simulation exits nonzero on failure, the log decides the result
./obj_dir/tb_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/e203_cpu_top_properties.sv ====
// Bus handshake and routing properties
`timescale 1ns/1ps
`default_nettype none

module e203_cpu_top_properties import e203_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       tcm_sd,
  input logic       core_icb_cmd_valid,
  input logic       core_icb_cmd_ready,
  input addr_t      core_icb_cmd_addr,
  input logic       core_icb_cmd_read,
  input data_t      core_icb_cmd_wdata,
  input mask_t      core_icb_cmd_wmask,
  input logic       core_icb_rsp_valid,
  input logic       core_icb_rsp_ready,
  input logic       core_icb_rsp_err,
  input data_t      core_icb_rsp_rdata,
  input logic       dtcm_icb_cmd_valid,
  input logic       dtcm_icb_cmd_ready,
  input dtcm_addr_t dtcm_icb_cmd_addr,
  input logic       ext2dtcm_icb_cmd_valid,
  input logic       ext2dtcm_icb_cmd_ready,
  input logic       ppi_icb_cmd_valid,
  input addr_t      ppi_icb_cmd_addr,
  input logic       ppi_icb_cmd_read,
  input data_t      ppi_icb_cmd_wdata,
  input mask_t      ppi_icb_cmd_wmask,
  input logic       mem_icb_cmd_valid,
  input addr_t      mem_icb_cmd_addr,
  input logic       mem_icb_cmd_read,
  input data_t      mem_icb_cmd_wdata,
  input mask_t      mem_icb_cmd_wmask
);

  int      fail_cnt = 0;
  target_e exp_tgt;

  // Region of the current core command
  always_comb begin
    if (core_icb_cmd_addr[31:16] == DTCM_ADDR_BASE[31:16]) begin
      exp_tgt = TGT_DTCM;
    end else if (core_icb_cmd_addr[31:27] == PPI_ADDR_BASE[31:27]) begin
      exp_tgt = TGT_PPI;
    end else begin
      exp_tgt = TGT_MEM;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core response holds until taken

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    core_icb_rsp_valid && !core_icb_rsp_ready |=> core_icb_rsp_valid &&
      $stable(core_icb_rsp_rdata) && $stable(core_icb_rsp_err))
    else begin
      fail_cnt++;
      $error("core response dropped or changed before transfer");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Routing

  ppi_route: assert property (@(posedge clk) disable iff (!rst_n)
    ppi_icb_cmd_valid |-> exp_tgt == TGT_PPI && ppi_icb_cmd_addr == core_icb_cmd_addr &&
      ppi_icb_cmd_read == core_icb_cmd_read && ppi_icb_cmd_wdata == core_icb_cmd_wdata &&
      ppi_icb_cmd_wmask == core_icb_cmd_wmask)
    else begin
      fail_cnt++;
      $error("PPI command does not match the core command");
    end

  mem_route: assert property (@(posedge clk) disable iff (!rst_n)
    mem_icb_cmd_valid |-> exp_tgt == TGT_MEM && mem_icb_cmd_addr == core_icb_cmd_addr &&
      mem_icb_cmd_read == core_icb_cmd_read && mem_icb_cmd_wdata == core_icb_cmd_wdata &&
      mem_icb_cmd_wmask == core_icb_cmd_wmask)
    else begin
      fail_cnt++;
      $error("MEM command does not match the core command");
    end

  dtcm_route: assert property (@(posedge clk) disable iff (!rst_n)
    dtcm_icb_cmd_valid |-> exp_tgt == TGT_DTCM &&
      dtcm_icb_cmd_addr == core_icb_cmd_addr[DTCM_ADDR_WIDTH-1:0])
    else begin
      fail_cnt++;
      $error("DTCM command does not match the core command");
    end

  // An accepted command reaches exactly one target
  one_target: assert property (@(posedge clk) disable iff (!rst_n)
    core_icb_cmd_valid && core_icb_cmd_ready |->
      $onehot({dtcm_icb_cmd_valid, ppi_icb_cmd_valid, mem_icb_cmd_valid}))
    else begin
      fail_cnt++;
      $error("accepted core command not on exactly one target");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Shutdown blocks the DTCM

  sd_block: assert property (@(posedge clk) disable iff (!rst_n)
    tcm_sd |-> !(dtcm_icb_cmd_valid && dtcm_icb_cmd_ready) &&
      !(ext2dtcm_icb_cmd_valid && ext2dtcm_icb_cmd_ready))
    else begin
      fail_cnt++;
      $error("DTCM command transferred during shutdown");
    end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for 8 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
// Data side memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

// PPI or MEM slave, answers with the inverted address
module icb_slave_model import e203_pkg::*; #(
  parameter addr_t ERR_ADDR = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  icb_cmd_valid,
  output logic  icb_cmd_ready,
  input  addr_t icb_cmd_addr,
  output logic  icb_rsp_valid,
  input  logic  icb_rsp_ready,
  output logic  icb_rsp_err,
  output data_t icb_rsp_rdata
);

  addr_t       pend[$];
  logic        cmd_hsk_q;
  logic        rsp_hsk_q;
  addr_t       addr_q;
  int unsigned delay;

  always @(posedge clk) begin
    if (!rst_n) begin
      cmd_hsk_q <= 1'b0;
      rsp_hsk_q <= 1'b0;
    end else begin
      cmd_hsk_q <= icb_cmd_valid & icb_cmd_ready;
      rsp_hsk_q <= icb_rsp_valid & icb_rsp_ready;
    end
    addr_q <= icb_cmd_addr;
  end

  initial begin
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp_err   = 1'b0;
    icb_rsp_rdata = '0;
    delay         = 0;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_hsk_q) begin
        pend.push_back(addr_q);
      end
      if (rsp_hsk_q) begin
        icb_rsp_valid = 1'b0;
      end
      icb_cmd_ready = ($urandom % 4) != 0;
      // Random gap before each response
      if (!icb_rsp_valid && pend.size() > 0) begin
        if (delay == 0) begin
          icb_rsp_valid = 1'b1;
          icb_rsp_rdata = data_t'(~pend[0]);
          icb_rsp_err   = (pend[0] == ERR_ADDR);
          void'(pend.pop_front());
          delay = $urandom % 4;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

module tb_top import e203_pkg::*; ();

  localparam int    TIMEOUT      = 200;
  localparam addr_t PPI_ERR_ADDR = 32'h1000_0010;
  localparam addr_t MEM_ERR_ADDR = 32'h8000_0040;

  logic       clk;
  logic       rst_n;
  logic       tcm_sd;
  logic       core_icb_cmd_valid;
  logic       core_icb_cmd_ready;
  addr_t      core_icb_cmd_addr;
  logic       core_icb_cmd_read;
  data_t      core_icb_cmd_wdata;
  mask_t      core_icb_cmd_wmask;
  logic       core_icb_rsp_valid;
  logic       core_icb_rsp_ready;
  logic       core_icb_rsp_err;
  data_t      core_icb_rsp_rdata;
  logic       ext2dtcm_icb_cmd_valid;
  logic       ext2dtcm_icb_cmd_ready;
  dtcm_addr_t ext2dtcm_icb_cmd_addr;
  logic       ext2dtcm_icb_cmd_read;
  data_t      ext2dtcm_icb_cmd_wdata;
  mask_t      ext2dtcm_icb_cmd_wmask;
  logic       ext2dtcm_icb_rsp_valid;
  logic       ext2dtcm_icb_rsp_ready;
  logic       ext2dtcm_icb_rsp_err;
  data_t      ext2dtcm_icb_rsp_rdata;
  logic       ppi_icb_cmd_valid;
  logic       ppi_icb_cmd_ready;
  addr_t      ppi_icb_cmd_addr;
  logic       ppi_icb_cmd_read;
  data_t      ppi_icb_cmd_wdata;
  mask_t      ppi_icb_cmd_wmask;
  logic       ppi_icb_rsp_valid;
  logic       ppi_icb_rsp_ready;
  logic       ppi_icb_rsp_err;
  data_t      ppi_icb_rsp_rdata;
  logic       mem_icb_cmd_valid;
  logic       mem_icb_cmd_ready;
  addr_t      mem_icb_cmd_addr;
  logic       mem_icb_cmd_read;
  data_t      mem_icb_cmd_wdata;
  mask_t      mem_icb_cmd_wmask;
  logic       mem_icb_rsp_valid;
  logic       mem_icb_rsp_ready;
  logic       mem_icb_rsp_err;
  data_t      mem_icb_rsp_rdata;

  // Values captured on the rising edge
  logic  core_cmd_hsk_q;
  logic  core_rsp_hsk_q;
  logic  core_rsp_err_q;
  data_t core_rsp_rdata_q;
  logic  ext_cmd_hsk_q;
  logic  ext_rsp_hsk_q;
  logic  ext_rsp_err_q;
  data_t ext_rsp_rdata_q;

  // Reference DTCM and expected core responses in issue order
  data_t ref_mem [int];
  data_t exp_rdata[$];
  logic  exp_err[$];
  logic  exp_chk[$];
  logic  slow_rsp;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  e203_cpu_top DUT (.*);

  bind e203_cpu_top e203_cpu_top_properties u_props (.*);

  icb_slave_model #(.ERR_ADDR(PPI_ERR_ADDR)) u_ppi_slave (
    .clk(clk), .rst_n(rst_n),
    .icb_cmd_valid(ppi_icb_cmd_valid), .icb_cmd_ready(ppi_icb_cmd_ready),
    .icb_cmd_addr(ppi_icb_cmd_addr), .icb_rsp_valid(ppi_icb_rsp_valid),
    .icb_rsp_ready(ppi_icb_rsp_ready), .icb_rsp_err(ppi_icb_rsp_err),
    .icb_rsp_rdata(ppi_icb_rsp_rdata)
  );

  icb_slave_model #(.ERR_ADDR(MEM_ERR_ADDR)) u_mem_slave (
    .clk(clk), .rst_n(rst_n),
    .icb_cmd_valid(mem_icb_cmd_valid), .icb_cmd_ready(mem_icb_cmd_ready),
    .icb_cmd_addr(mem_icb_cmd_addr), .icb_rsp_valid(mem_icb_rsp_valid),
    .icb_rsp_ready(mem_icb_rsp_ready), .icb_rsp_err(mem_icb_rsp_err),
    .icb_rsp_rdata(mem_icb_rsp_rdata)
  );

  always @(posedge clk) begin
    if (!rst_n) begin
      core_cmd_hsk_q <= 1'b0;
      core_rsp_hsk_q <= 1'b0;
      ext_cmd_hsk_q  <= 1'b0;
      ext_rsp_hsk_q  <= 1'b0;
    end else begin
      core_cmd_hsk_q <= core_icb_cmd_valid & core_icb_cmd_ready;
      core_rsp_hsk_q <= core_icb_rsp_valid & core_icb_rsp_ready;
      ext_cmd_hsk_q  <= ext2dtcm_icb_cmd_valid & ext2dtcm_icb_cmd_ready;
      ext_rsp_hsk_q  <= ext2dtcm_icb_rsp_valid & ext2dtcm_icb_rsp_ready;
    end
    core_rsp_err_q   <= core_icb_rsp_err;
    core_rsp_rdata_q <= core_icb_rsp_rdata;
    ext_rsp_err_q    <= ext2dtcm_icb_rsp_err;
    ext_rsp_rdata_q  <= ext2dtcm_icb_rsp_rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input mask_t m);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Update the DTCM model, returns whether a read has a known value
  function automatic logic model_access(input int w, input logic read, input data_t wdata,
                                        input mask_t m, output data_t rdata);
    rdata = ref_mem.exists(w) ? ref_mem[w] : '0;
    if (!read) begin
      ref_mem[w] = merge_bytes(rdata, wdata, m);
    end
    return read && ref_mem.exists(w);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Core port

  task automatic core_expect(input addr_t addr, input logic read, input data_t wdata,
                             input mask_t m);
    data_t rd;
    logic  chk;
    if (addr[31:16] == 16'h9000) begin
      chk = model_access(int'(addr[15:2]), read, wdata, m, rd);
      exp_err.push_back(1'b0);
    end else begin
      rd  = data_t'(~addr);
      chk = 1'b1;
      exp_err.push_back(addr == PPI_ERR_ADDR || addr == MEM_ERR_ADDR);
    end
    exp_rdata.push_back(rd);
    exp_chk.push_back(chk);
  endtask

  task automatic core_drive(input addr_t addr, input logic read, input data_t wdata,
                            input mask_t m);
    core_icb_cmd_valid = 1'b1;
    core_icb_cmd_addr  = addr;
    core_icb_cmd_read  = read;
    core_icb_cmd_wdata = wdata;
    core_icb_cmd_wmask = m;
  endtask

  task automatic core_wait_accept();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_now("core command was not accepted in time");
    end while (!core_cmd_hsk_q);
  endtask

  task automatic core_issue(input addr_t addr, input logic read, input data_t wdata,
                            input mask_t m);
    core_expect(addr, read, wdata, m);
    core_drive(addr, read, wdata, m);
    core_wait_accept();
  endtask

  task automatic drain_responses();
    int cycles;
    core_icb_cmd_valid = 1'b0;
    cycles = 0;
    while (exp_rdata.size() > 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_now("core responses missing after timeout");
    end
  endtask

  // Random command to one of the three regions
  task automatic core_random_mix(input int count);
    addr_t addr;
    for (int i = 0; i < count; i++) begin
      case ($urandom % 3)
        0:       addr = DTCM_ADDR_BASE + 32'(($urandom % 8) * 4);
        1:       addr = PPI_ADDR_BASE + 32'(($urandom % 16) * 4);
        default: addr = 32'h8000_0000 + 32'(($urandom % 32) * 4);
      endcase
      if (i == 3) addr = PPI_ERR_ADDR;
      if (i == 7) addr = MEM_ERR_ADDR;
      core_issue(addr, 1'($urandom % 2), data_t'($urandom), mask_t'($urandom));
    end
    drain_responses();
  endtask

  // Responses must match the expectations in issue order
  always @(negedge clk) begin
    if (rst_n) begin
      if (core_rsp_hsk_q) begin
        if (exp_rdata.size() == 0) fail_now("core response with no command outstanding");
        if (exp_chk[0]) check_value("core_icb_rsp_rdata", core_rsp_rdata_q, exp_rdata[0]);
        check_value("core_icb_rsp_err", data_t'(core_rsp_err_q), data_t'(exp_err[0]));
        void'(exp_rdata.pop_front());
        void'(exp_err.pop_front());
        void'(exp_chk.pop_front());
      end
      core_icb_rsp_ready = slow_rsp ? (($urandom % 3) == 0) : 1'b1;
    end
  end

  always @(negedge clk) begin
    if (DUT.u_props.fail_cnt != 0) fail_now("a bound DUT assertion failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // ext2dtcm port, one access at a time

  task automatic ext_access(input dtcm_addr_t offset, input logic read, input data_t wdata,
                            input mask_t m);
    int    cycles;
    data_t rd;
    logic  chk;
    chk = model_access(int'(offset[15:2]), read, wdata, m, rd);
    ext2dtcm_icb_cmd_valid = 1'b1;
    ext2dtcm_icb_cmd_addr  = offset;
    ext2dtcm_icb_cmd_read  = read;
    ext2dtcm_icb_cmd_wdata = wdata;
    ext2dtcm_icb_cmd_wmask = m;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_now("ext2dtcm command was not accepted in time");
    end while (!ext_cmd_hsk_q);
    ext2dtcm_icb_cmd_valid = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_now("ext2dtcm response missing after timeout");
    end while (!ext_rsp_hsk_q);
    if (chk) check_value("ext2dtcm_icb_rsp_rdata", ext_rsp_rdata_q, rd);
    check_value("ext2dtcm_icb_rsp_err", data_t'(ext_rsp_err_q), '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int cycles;
    void'($urandom(32'h7f65de0e));
    tcm_sd                 = 1'b0;
    slow_rsp               = 1'b0;
    core_icb_rsp_ready     = 1'b1;
    ext2dtcm_icb_rsp_ready = 1'b1;
    core_drive('0, 1'b1, '0, '0);
    core_icb_cmd_valid     = 1'b0;
    ext2dtcm_icb_cmd_valid = 1'b0;
    ext2dtcm_icb_cmd_addr  = '0;
    ext2dtcm_icb_cmd_read  = 1'b1;
    ext2dtcm_icb_cmd_wdata = '0;
    ext2dtcm_icb_cmd_wmask = '0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_now("reset never released");
    end while (!rst_n);

    // Masked writes then reads of the DTCM
    for (int w = 0; w < 8; w++) begin
      core_issue(DTCM_ADDR_BASE + 32'(w * 4), 1'b0, data_t'($urandom), 4'hf);
    end
    for (int i = 0; i < 24; i++) begin
      core_issue(DTCM_ADDR_BASE + 32'(($urandom % 8) * 4), 1'b0, data_t'($urandom),
                 mask_t'($urandom));
    end
    for (int w = 0; w < 8; w++) begin
      core_issue(DTCM_ADDR_BASE + 32'(w * 4), 1'b1, '0, '0);
    end
    drain_responses();

    // Both masters share one array
    ext_access(16'h0040, 1'b0, 32'hcafe_0040, 4'hf);
    core_issue(32'h9000_0040, 1'b1, '0, '0);
    core_issue(32'h9000_0044, 1'b0, 32'h1234_5678, 4'hf);
    drain_responses();
    ext_access(16'h0044, 1'b1, '0, '0);
    ext_access(16'h0044, 1'b0, 32'haabb_ccdd, 4'b0101);
    core_issue(32'h9000_0044, 1'b1, '0, '0);
    drain_responses();

    // Back to back mix over all regions
    core_random_mix(24);

    // Core response back-pressure
    slow_rsp = 1'b1;
    core_random_mix(32);
    slow_rsp = 1'b0;

    // DTCM shutdown stalls a pending read
    core_issue(32'h9000_0100, 1'b0, 32'h5a5a_a5a5, 4'hf);
    drain_responses();
    tcm_sd = 1'b1;
    core_expect(32'h9000_0100, 1'b1, '0, '0);
    core_drive(32'h9000_0100, 1'b1, '0, '0);
    repeat (10) begin
      @(negedge clk);
      if (core_cmd_hsk_q) fail_now("DTCM read accepted during shutdown");
    end
    tcm_sd = 1'b0;
    core_wait_accept();
    drain_responses();

    // Shutdown stalls the external master the same way
    tcm_sd = 1'b1;
    fork
      ext_access(16'h0100, 1'b1, '0, '0);
      begin
        repeat (10) @(negedge clk);
        tcm_sd = 1'b0;
      end
    join

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
